//--- vlog.f
+incdir+.
txframe_pkg.sv
transport_input_stage.sv
lane_mapper.sv
link_output_stage.sv
jesd_tx_assembler.sv
tb_clock_gen.sv
tb_jesd_tx_assembler.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the JESD204 TX assembler testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_jesd_tx_assembler \
   -f vlog.f \
   -o sim_jesd_tx

output=$(./obj_dir/sim_jesd_tx)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "^Simulation PASSED$"; then
   exit 0
fi
exit 1

//--- tb_jesd_tx_assembler.sv
// Directed tests, reference lane model and error counting for the JESD204 TX assembler

`timescale 1ns/1ps

`include "txframe_consts.svh"

module tb_jesd_tx_assembler;

   localparam int wait_limit = 20;

   logic                               txframe_clk;
   logic                               txframe_rst_n;
   logic                               link_tprt_early_txdata_ready;
   logic                               jesd_tx_data_valid;
   logic [`TXF_DATA_W-1:0]             jesd_tx_datain;
   logic [`TXF_SLOTS-1:0]              tprt_avalon_tx_control;
   logic [4:0]                         csr_l;
   logic [4:0]                         csr_n;
   logic [7:0]                         csr_f;
   logic                               jesd_tx_data_ready;
   logic [`TXF_LANES*`TXF_LANE_W-1:0]  tprt_link_txdata;
   logic                               tprt_link_txdata_valid;
   logic                               tprt_link_txdata_error;
   int                                 errors;
   int                                 checks;

   tb_clock_gen u_clk (.txframe_clk(txframe_clk), .txframe_rst_n(txframe_rst_n));

   jesd_tx_assembler dut0 (.*);

   task automatic check_value(input string test, input string what,
                              input logic [127:0] expected, input logic [127:0] actual);
      checks++;
      if (actual !== expected)
      begin
         $display("MISMATCH %s %s: expected %h actual %h", test, what, expected, actual);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model from N-bit samples to 16-bit nibble groups to lanes
   ////////////////////////////////////////////////////////////////////////////

   task automatic model_lanes(input logic [127:0] din, input logic [7:0] ctrl, input int n,
                              input int f_code, input int l_code, input logic rdy,
                              output logic [127:0] lanes_exp);
      logic [15:0] slots [8];
      logic [15:0] sample;
      logic [31:0] word;
      for (int j = 0; j < `TXF_SLOTS; j++)
      begin
         sample = '0;
         for (int b = 0; b < n; b++)
            sample[b] = din[j*n + b];
         // Sample on top, control bit just below it, zero tail
         slots[j] = sample << (16 - n);
         if (n < 16)
            slots[j][15 - n] = ctrl[j];
      end
      lanes_exp = '0;
      for (int i = 0; i < `TXF_LANES; i++)
      begin
         if (f_code == 3)
            word = {slots[2*i], slots[2*i+1]};
         else if (f_code == 1)
            word = {slots[i], slots[i+4]};
         else
            word = '0;
         if (rdy && i <= l_code)
            lanes_exp[32*i +: 32] = word;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers that start and end on a falling edge
   ////////////////////////////////////////////////////////////////////////////

   task automatic configure(input int n, input int f_code, input int l_code);
      csr_n = 5'(n - 1);
      csr_f = 8'(f_code);
      csr_l = 5'(l_code);
      @(negedge txframe_clk);
   endtask

   task automatic set_early_ready(input string test, input logic level);
      int cycles;
      link_tprt_early_txdata_ready = level;
      cycles = 0;
      do
      begin
         @(negedge txframe_clk);
         cycles++;
      end
      while (jesd_tx_data_ready !== level && cycles < wait_limit);
      if (jesd_tx_data_ready !== level)
      begin
         $display("%s: jesd_tx_data_ready never followed early ready", test);
         errors++;
      end
      else
         check_value(test, "ready latency", 128'(1), 128'(cycles));
   endtask

   // One beat checked one cycle later against the model
   task automatic send_beat(input string test, input logic valid);
      logic [127:0] din;
      logic [7:0]   ctrl;
      logic         rdy;
      logic [127:0] lanes_exp;
      din  = {$urandom, $urandom, $urandom, $urandom};
      ctrl = 8'($urandom);
      rdy  = link_tprt_early_txdata_ready;
      jesd_tx_datain         = din;
      tprt_avalon_tx_control = ctrl;
      jesd_tx_data_valid     = valid;
      model_lanes(din, ctrl, int'(csr_n) + 1, int'(csr_f), int'(csr_l), rdy, lanes_exp);
      check_value(test, "data ready", 128'(rdy), 128'(jesd_tx_data_ready));
      @(negedge txframe_clk);
      check_value(test, "lanes", lanes_exp, tprt_link_txdata);
      check_value(test, "valid flag", 128'(rdy & valid), 128'(tprt_link_txdata_valid));
      check_value(test, "error flag", 128'(rdy & ~valid), 128'(tprt_link_txdata_error));
   endtask

   task automatic check_idle(input string test);
      check_value(test, "data ready", '0, 128'(jesd_tx_data_ready));
      check_value(test, "lanes", '0, tprt_link_txdata);
      check_value(test, "valid flag", '0, 128'(tprt_link_txdata_valid));
      check_value(test, "error flag", '0, 128'(tprt_link_txdata_error));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic reset_behavior();
      int cycles;
      cycles = 0;
      do
      begin
         @(negedge txframe_clk);
         check_idle("reset");
         cycles++;
      end
      while (!txframe_rst_n && cycles < wait_limit);
      if (!txframe_rst_n)
      begin
         $display("reset: reset was never released");
         errors++;
      end
      // Early ready still low, so nothing may move
      repeat (3)
      begin
         @(negedge txframe_clk);
         check_idle("reset");
      end
   endtask

   task automatic packing_all_n();
      configure(12, 3, 3);
      set_early_ready("packing", 1'b1);
      for (int n = 12; n <= 16; n++)
      begin
         configure(n, 3, 3);
         repeat (4)
            send_beat($sformatf("packing_n%0d", n), 1'b1);
      end
   endtask

   task automatic f2_mapping();
      configure(16, 1, 3);
      repeat (4)
         send_beat("f2_mapping_n16", 1'b1);
      configure(13, 1, 3);
      repeat (4)
         send_beat("f2_mapping_n13", 1'b1);
   endtask

   task automatic lane_powerdown();
      for (int f_code = 1; f_code <= 3; f_code += 2)
      begin
         configure(14, f_code, 1);
         repeat (3)
         begin
            send_beat("lane_powerdown", 1'b1);
            check_value("lane_powerdown", "lanes 3..2", '0, {64'd0, tprt_link_txdata[127:64]});
         end
      end
   endtask

   task automatic ready_gating();
      configure(16, 3, 3);
      set_early_ready("ready_gating", 1'b0);
      send_beat("ready_gating_low", 1'b1);
      send_beat("ready_gating_low", 1'b0);
      set_early_ready("ready_gating", 1'b1);
      send_beat("ready_gating_underflow", 1'b0);
      send_beat("ready_gating_accept", 1'b1);
   endtask

   task automatic illegal_f_code();
      configure(12, 0, 3);
      repeat (3)
         send_beat("illegal_f_code0", 1'b1);
      configure(12, 2, 3);
      send_beat("illegal_f_code2", 1'b1);
   endtask

   initial
   begin
      errors = 0;
      checks = 0;
      void'($urandom(61));
      link_tprt_early_txdata_ready = 1'b0;
      jesd_tx_data_valid           = 1'b0;
      jesd_tx_datain               = '0;
      tprt_avalon_tx_control       = '0;
      csr_l                        = 5'd0;
      csr_n                        = 5'd11;
      csr_f                        = 8'd0;

      reset_behavior();
      packing_all_n();
      f2_mapping();
      lane_powerdown();
      ready_gating();
      illegal_f_code();

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Simulation PASSED");
      end
      else
      begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- tb_clock_gen.sv
// Testbench clock and synchronous reset generator

`timescale 1ns/1ps

module tb_clock_gen
#(
   parameter real period_ns    = 8.0,
   parameter int  reset_cycles = 3
)
(
   output logic txframe_clk,
   output logic txframe_rst_n
);

   initial
   begin
      txframe_clk = 1'b0;
      forever
         #(period_ns / 2.0) txframe_clk = ~txframe_clk;
   end

   // Release on a falling edge, away from the sampling edge
   initial
   begin
      txframe_rst_n = 1'b0;
      repeat (reset_cycles)
         @(posedge txframe_clk);
      @(negedge txframe_clk);
      txframe_rst_n = 1'b1;
   end

endmodule

//--- jesd_tx_assembler.sv
// Top level of the JESD204 TX transport layer

`timescale 1ns/1ps

`include "txframe_consts.svh"

module jesd_tx_assembler
(
   input  logic                                txframe_clk,
   input  logic                                txframe_rst_n,
   input  logic                                link_tprt_early_txdata_ready,
   input  logic                                jesd_tx_data_valid,
   input  logic [`TXF_DATA_W-1:0]              jesd_tx_datain,
   input  logic [`TXF_SLOTS-1:0]               tprt_avalon_tx_control,
   input  logic [4:0]                          csr_l,
   input  logic [4:0]                          csr_n,
   input  logic [7:0]                          csr_f,
   output logic                                jesd_tx_data_ready,
   output logic [`TXF_LANES*`TXF_LANE_W-1:0]   tprt_link_txdata,
   output logic                                tprt_link_txdata_valid,
   output logic                                tprt_link_txdata_error
);

   import txframe_pkg::*;

   txframe_cfg_t  cfg;
   slot_frame_t   frame;
   lane_frame_t   lanes;
   logic          map_ready;
   logic          map_valid;

   transport_input_stage u_input
   (
      .txframe_clk                  (txframe_clk),
      .txframe_rst_n                (txframe_rst_n),
      .link_tprt_early_txdata_ready (link_tprt_early_txdata_ready),
      .jesd_tx_data_valid           (jesd_tx_data_valid),
      .jesd_tx_datain               (jesd_tx_datain),
      .tprt_avalon_tx_control       (tprt_avalon_tx_control),
      .csr_l                        (csr_l),
      .csr_n                        (csr_n),
      .csr_f                        (csr_f),
      .jesd_tx_data_ready           (jesd_tx_data_ready),
      .cfg                          (cfg),
      .frame                        (frame)
   );

   lane_mapper u_mapper
   (
      .cfg   (cfg),
      .frame (frame),
      .lanes (lanes),
      .ready (map_ready),
      .valid (map_valid)
   );

   link_output_stage u_output
   (
      .txframe_clk            (txframe_clk),
      .txframe_rst_n          (txframe_rst_n),
      .lanes                  (lanes),
      .ready                  (map_ready),
      .valid                  (map_valid),
      .tprt_link_txdata       (tprt_link_txdata),
      .tprt_link_txdata_valid (tprt_link_txdata_valid),
      .tprt_link_txdata_error (tprt_link_txdata_error)
   );

endmodule

//--- link_output_stage.sv
// Output register for lane data, accepted-beat flag and underflow flag

`timescale 1ns/1ps

`include "txframe_consts.svh"

module link_output_stage
(
   input  logic                                   txframe_clk,
   input  logic                                   txframe_rst_n,
   input  txframe_pkg::lane_frame_t               lanes,
   input  logic                                   ready,
   input  logic                                   valid,
   output logic [`TXF_LANES*`TXF_LANE_W-1:0]      tprt_link_txdata,
   output logic                                   tprt_link_txdata_valid,
   output logic                                   tprt_link_txdata_error
);

   ////////////////////////////////////////////////////////////////////////////
   // Link side register stage
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge txframe_clk)
   begin
      if (!txframe_rst_n)
      begin
         tprt_link_txdata       <= '0;
         tprt_link_txdata_valid <= 1'b0;
         tprt_link_txdata_error <= 1'b0;
      end
      else
      begin
         tprt_link_txdata       <= lanes.lane;
         // Accepted beat
         tprt_link_txdata_valid <= ready & valid;
         // Link pulled a beat the converter did not supply
         tprt_link_txdata_error <= ready & ~valid;
      end
   end

   // Any non-zero lane word must come from a beat the link pulled
   a_data_only_when_pulled : assert property (@(posedge txframe_clk)
      disable iff (!txframe_rst_n)
      (tprt_link_txdata != '0) |-> (tprt_link_txdata_valid || tprt_link_txdata_error));

endmodule

//--- lane_mapper.sv
// Slot to lane mapping for F=2 and F=4 with lane power-down and ready gating

`timescale 1ns/1ps

`include "txframe_consts.svh"

module lane_mapper
(
   input  txframe_pkg::txframe_cfg_t   cfg,
   input  txframe_pkg::slot_frame_t    frame,
   output txframe_pkg::lane_frame_t    lanes,
   output logic                        ready,
   output logic                        valid
);

   import txframe_pkg::*;

   lane_word_t [`TXF_LANES-1:0] mapped;

   ////////////////////////////////////////////////////////////////////////////
   // Lane assembly
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      for (int i = 0; i < `TXF_LANES; i++)
      begin
         case (cfg.f_mode)
            // Two adjacent samples share one lane
            F_MODE_4:
            begin
               mapped[i] = {frame.slot[2*i], frame.slot[2*i+1]};
            end
            // Frame clock runs at half rate, two beats interleaved
            F_MODE_2:
            begin
               mapped[i] = {frame.slot[i], frame.slot[i+`TXF_LANES]};
            end
            default:
            begin
               mapped[i] = '0;
            end
         endcase

         // Powered-down lanes and non-ready beats carry zeros
         if (!cfg.lane_en[i] || !frame.ready)
         begin
            mapped[i] = '0;
         end
      end
   end

   assign lanes.lane = mapped;

   // Handshake bits go on to the output register
   assign ready = frame.ready;
   assign valid = frame.valid;

endmodule

//--- transport_input_stage.sv
// Input stage: CSR registers and decode, early ready register, sample to slot packing

`timescale 1ns/1ps

`include "txframe_consts.svh"

module transport_input_stage
(
   input  logic                        txframe_clk,
   input  logic                        txframe_rst_n,
   input  logic                        link_tprt_early_txdata_ready,
   input  logic                        jesd_tx_data_valid,
   input  logic [`TXF_DATA_W-1:0]      jesd_tx_datain,
   input  logic [`TXF_SLOTS-1:0]       tprt_avalon_tx_control,
   input  logic [4:0]                  csr_l,
   input  logic [4:0]                  csr_n,
   input  logic [7:0]                  csr_f,
   output logic                        jesd_tx_data_ready,
   output txframe_pkg::txframe_cfg_t   cfg,
   output txframe_pkg::slot_frame_t    frame
);

   import txframe_pkg::*;

   logic                    early_ready_q;
   logic [4:0]              n_code;
   logic [4:0]              n_bits;
   logic [4:0]              pad;
   logic                    n_legal;
   f_mode_t                 f_mode_next;
   logic [`TXF_LANES-1:0]   lane_en_next;
   slot_t [`TXF_SLOTS-1:0]  slots;

   ////////////////////////////////////////////////////////////////////////////
   // CSR decode
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (csr_f)
         8'd1:    f_mode_next = F_MODE_2;
         8'd3:    f_mode_next = F_MODE_4;
         default: f_mode_next = F_MODE_OFF;
      endcase
      // Lanes above csr_l are powered down
      for (int i = 0; i < `TXF_LANES; i++)
      begin
         lane_en_next[i] = (csr_l >= 5'(i));
      end
   end

   always_ff @(posedge txframe_clk)
   begin
      if (!txframe_rst_n)
      begin
         early_ready_q <= 1'b0;
         n_code        <= 5'd0;
         cfg.f_mode    <= F_MODE_OFF;
         cfg.lane_en   <= '0;
      end
      else
      begin
         early_ready_q <= link_tprt_early_txdata_ready;
         n_code        <= csr_n;
         cfg.f_mode    <= f_mode_next;
         cfg.lane_en   <= lane_en_next;
      end
   end

   assign jesd_tx_data_ready = early_ready_q;

   ////////////////////////////////////////////////////////////////////////////
   // Sample packing into N' = 16 nibble groups
   ////////////////////////////////////////////////////////////////////////////

   assign n_bits  = n_code + 5'd1;
   assign pad     = 5'(`TXF_SLOT_W) - n_bits;
   assign n_legal = (n_code >= 5'(`TXF_N_MIN_CODE)) && (n_code <= 5'(`TXF_N_MAX_CODE));

   always_comb
   begin : pack_slots
      logic [`TXF_DATA_W-1:0] shifted;
      slot_t                  sample;
      slot_t                  ctrl_word;
      for (int j = 0; j < `TXF_SLOTS; j++)
      begin
         // Sample j starts at bit j*N
         shifted   = jesd_tx_datain >> (j * n_bits);
         sample    = shifted[`TXF_SLOT_W-1:0] & ({`TXF_SLOT_W{1'b1}} >> pad);
         ctrl_word = {{(`TXF_SLOT_W-1){1'b0}}, tprt_avalon_tx_control[j]};
         if (!n_legal)
            slots[j] = '0;
         else if (pad == 5'd0)
            slots[j] = sample;                 // N=16, no room for control
         else
            slots[j] = (sample << pad) | (ctrl_word << (pad - 5'd1));
      end
   end

   assign frame.slot  = slots;
   assign frame.ready = early_ready_q;
   assign frame.valid = jesd_tx_data_valid;

   // Link must only pull data with a legal N programmed
   a_n_code_legal : assert property (@(posedge txframe_clk) disable iff (!txframe_rst_n)
      early_ready_q |-> n_legal);

endmodule

//--- txframe_pkg.sv
// Configuration, slot frame and lane word types of the TX transport layer

`include "txframe_consts.svh"

package txframe_pkg;

   // Decoded octets-per-frame setting
   typedef enum logic [1:0]
   {
      F_MODE_OFF = 2'd0,
      F_MODE_2   = 2'd1,
      F_MODE_4   = 2'd2
   } f_mode_t;

   typedef logic [`TXF_SLOT_W-1:0] slot_t;
   typedef logic [`TXF_LANE_W-1:0] lane_word_t;

   // Registered CSR view used by the mapper
   typedef struct packed
   {
      f_mode_t                f_mode;
      logic [`TXF_LANES-1:0]  lane_en;
   } txframe_cfg_t;

   // One beat of packed nibble groups, slot j is sample j
   typedef struct packed
   {
      slot_t [`TXF_SLOTS-1:0] slot;
      logic                   ready;
      logic                   valid;
   } slot_frame_t;

   // Lane i sits at bits 32i upward
   typedef struct packed
   {
      lane_word_t [`TXF_LANES-1:0] lane;
   } lane_frame_t;

endpackage

//--- txframe_consts.svh
// Lane count, slot count and bus width constants for the TX transport layer

`ifndef TXFRAME_CONSTS_SVH
`define TXFRAME_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Link geometry
////////////////////////////////////////////////////////////////////////////

// Lanes toward the link layer
`define TXF_LANES 4

// Sample slots per frame clock beat
`define TXF_SLOTS 8

// N' nibble group width, one slot
`define TXF_SLOT_W 16

// One lane word per frame clock beat
`define TXF_LANE_W 32

// Packed converter sample bus
`define TXF_DATA_W (`TXF_SLOTS * `TXF_SLOT_W)

// Legal csr_n codes, N-1 for N = 12..16
`define TXF_N_MIN_CODE 11
`define TXF_N_MAX_CODE 15

`endif
